//--- Bender.yml
package:
  name: legacy_demod

sources:
  # RTL in compile order
  - files:
      - hdl/demodModePkg.sv
      - hdl/demodRegMapPkg.sv
      - hdl/demodApbRegs.sv
      - hdl/symbolRouter.sv
      - hdl/dacOutputMux.sv
      - hdl/legacyDemodTop.sv
  - target: simulation
    include_dirs:
      - sim
    files:
      - sim/legacyDemodTb.sv

//--- hdl/dacOutputMux.sv
// Selects the source of each DAC channel and holds the 14-bit code between syncs
module dacOutputMux (
    input  logic                      clk,
    input  logic                      clockCounterEn,
    input  demodModePkg::demodMode_t  demodMode,
    input  logic                      demod0Sync,
    input  logic                      demod1Sync,
    input  logic                      demod2Sync,
    input  demodModePkg::sample_t     demod0Out,
    input  demodModePkg::sample_t     demod1Out,
    input  demodModePkg::sample_t     demod2Out,
    input  logic                      multihDac0En,
    input  logic                      multihDac1En,
    input  logic                      multihDac2En,
    input  logic                      multihDac0Sync,
    input  logic                      multihDac1Sync,
    input  logic                      multihDac2Sync,
    input  demodModePkg::sample_t     multihDac0Data,
    input  demodModePkg::sample_t     multihDac1Data,
    input  demodModePkg::sample_t     multihDac2Data,
    output logic                      dac0Sync,
    output logic                      dac1Sync,
    output logic                      dac2Sync,
    output demodModePkg::dac_t        dac0Data,
    output demodModePkg::dac_t        dac1Data,
    output demodModePkg::dac_t        dac2Data
);

    import demodModePkg::*;

    logic                multihMode;
    logic [NUM_DACS-1:0] demodSync;
    logic [NUM_DACS-1:0] multihEn;
    logic [NUM_DACS-1:0] multihSync;
    logic [NUM_DACS-1:0] selSync;
    sample_t             demodData  [NUM_DACS];
    sample_t             multihData [NUM_DACS];
    dac_t                dacHold    [NUM_DACS];

    assign multihMode = (demodMode == MODE_MULTIH);

    // Gather the loose channel ports
    assign demodSync     = {demod2Sync, demod1Sync, demod0Sync};
    assign multihEn      = {multihDac2En, multihDac1En, multihDac0En};
    assign multihSync    = {multihDac2Sync, multihDac1Sync, multihDac0Sync};
    assign demodData[0]  = demod0Out;
    assign demodData[1]  = demod1Out;
    assign demodData[2]  = demod2Out;
    assign multihData[0] = multihDac0Data;
    assign multihData[1] = multihDac1Data;
    assign multihData[2] = multihDac2Data;

    //******************************
    // Per-channel select and hold
    //******************************
    for (genvar k = 0; k < NUM_DACS; k++) begin : channel
        logic       useMultih;
        dacSample_u selSample;

        assign useMultih = multihEn[k] && multihMode;

        always_ff @(posedge clk) begin
            selSample.raw <= useMultih ? multihData[k] : demodData[k];
        end

        always_ff @(posedge clk or posedge clockCounterEn) begin
            if (clockCounterEn) begin
                selSync[k] <= 1'b0;
                dacHold[k] <= '0;
            end else begin
                selSync[k] <= useMultih ? multihSync[k] : demodSync[k];
                // Low bits fall away here
                if (selSync[k]) begin
                    dacHold[k] <= selSample.fields.dacCode;
                end
            end
        end
    end

    assign dac0Sync = selSync[0];
    assign dac1Sync = selSync[1];
    assign dac2Sync = selSync[2];
    assign dac0Data = dacHold[0];
    assign dac1Data = dacHold[1];
    assign dac2Data = dacHold[2];

endmodule

//--- hdl/demodApbRegs.sv
// APB register slave for mode, clock counter, reboot address and image identification
module demodApbRegs (
    input  logic                                          clk,
    input  logic                                          clockCounterEn,
    input  logic                                          psel,
    input  logic                                          penable,
    input  logic                                          pwrite,
    input  demodRegMapPkg::regAddr_t                      paddr,
    input  demodRegMapPkg::regData_t                      pwdata,
    output demodRegMapPkg::regData_t                      prdata,
    output logic                                          pready,
    output logic                                          pslverr,
    output demodModePkg::demodMode_t                      demodMode,
    output logic [demodRegMapPkg::BOOT_ADDR_WIDTH-1:0]    rebootAddr,
    output logic                                          rebootPulse
);

    import demodModePkg::*;
    import demodRegMapPkg::*;

    logic     setupPhase;
    logic     accessPhase;
    logic     wrEn;
    logic     rdEn;
    logic     addrHit;
    regData_t clockCounter;
    regData_t clockHold;

    //******************************
    // Bus phases and decode
    //******************************
    assign setupPhase  = psel & ~penable;
    assign accessPhase = psel & penable;

    // Unmapped offsets never write
    assign wrEn = accessPhase & pwrite & addrHit;
    assign rdEn = accessPhase & ~pwrite;

    always_comb begin
        case (paddr)
            MISC_RESET, MISC_VERSION, MISC_CLOCK,
            MISC_TYPE, REBOOT_ADDR, DEMOD_MODE: addrHit = 1'b1;
            default:                            addrHit = 1'b0;
        endcase
    end

    // Zero-wait slave
    assign pready  = 1'b1;
    assign pslverr = accessPhase & ~addrHit;

    //******************************
    // Registers
    //******************************
    always_ff @(posedge clk or posedge clockCounterEn) begin
        if (clockCounterEn) begin
            demodMode    <= MODE_FM;
            rebootAddr   <= '0;
            rebootPulse  <= 1'b0;
            clockCounter <= '0;
            clockHold    <= '0;
        end else begin
            rebootPulse <= wrEn && (paddr == REBOOT_ADDR);
            if (wrEn && (paddr == DEMOD_MODE)) begin
                demodMode <= pwdata[$bits(demodMode_t)-1:0];
            end
            if (wrEn && (paddr == REBOOT_ADDR)) begin
                rebootAddr <= pwdata[BOOT_ADDR_WIDTH-1:0];
            end
            // Restart reads zero in the cycle after the access
            if (wrEn && (paddr == MISC_CLOCK)) begin
                clockCounter <= '0;
            end else begin
                clockCounter <= clockCounter + 1'b1;
            end
            // Sample on the setup cycle so the access returns a stable value
            if (setupPhase && !pwrite && (paddr == MISC_CLOCK)) begin
                clockHold <= clockCounter;
            end
        end
    end

    //******************************
    // Read mux
    //******************************
    always_comb begin
        prdata = '0;
        if (rdEn) begin
            case (paddr)
                MISC_VERSION: prdata = {VER_NUMBER, 16'h0000};
                MISC_CLOCK:   prdata = clockHold;
                MISC_TYPE:    prdata = {16'h0000, IMAGE_TYPE};
                REBOOT_ADDR:  prdata = regData_t'(rebootAddr);
                DEMOD_MODE:   prdata = regData_t'(demodMode);
                default:      prdata = '0;
            endcase
        end
    end

    //******************************
    // Protocol checks
    //******************************
    // Single access cycle per transfer since pready never drops
    penableAfterSetup: assert property (
        @(posedge clk) disable iff (clockCounterEn)
        penable |-> $past(psel && !penable)
    );

    rebootPulseSingle: assert property (
        @(posedge clk) disable iff (clockCounterEn)
        rebootPulse |=> !rebootPulse
    );

endmodule

//--- hdl/demodModePkg.sv
// Mode codes, sample widths and the DAC sample word shared by the demodulator datapath
package demodModePkg;

    //******************************
    // Demodulator modes
    //******************************
    typedef logic [4:0] demodMode_t;

    localparam demodMode_t MODE_FM     = 5'd0;
    localparam demodMode_t MODE_AQPSK  = 5'd2;
    localparam demodMode_t MODE_AUQPSK = 5'd3;
    localparam demodMode_t MODE_2FSK   = 5'd5;
    localparam demodMode_t MODE_MULTIH = 5'd16;

    //******************************
    // Sample and DAC widths
    //******************************
    localparam int SAMPLE_WIDTH = 18;
    localparam int DAC_WIDTH    = 14;
    localparam int DAC_DROP     = 4;
    localparam int NUM_DACS     = 3;

    typedef logic signed [SAMPLE_WIDTH-1:0] sample_t;
    typedef logic [DAC_WIDTH-1:0] dac_t;

    // Same 18-bit word, seen as a sample or as DAC code plus discarded LSBs
    typedef union packed {
        logic signed [SAMPLE_WIDTH-1:0] raw;
        struct packed {
            logic [DAC_WIDTH-1:0] dacCode;
            logic [DAC_DROP-1:0]  dropBits;
        } fields;
    } dacSample_u;

endpackage

//--- hdl/demodRegMapPkg.sv
// Host register map of the demodulator control block, with its identification constants
package demodRegMapPkg;

    //******************************
    // Bus widths
    //******************************
    localparam int REG_ADDR_WIDTH  = 12;
    localparam int REG_DATA_WIDTH  = 32;
    localparam int BOOT_ADDR_WIDTH = 24;

    typedef logic [REG_ADDR_WIDTH-1:0] regAddr_t;
    typedef logic [REG_DATA_WIDTH-1:0] regData_t;

    //******************************
    // Register offsets
    //******************************
    // Word aligned offsets with the misc space at zero
    localparam regAddr_t MISC_RESET   = 12'h000;
    localparam regAddr_t MISC_VERSION = 12'h004;
    localparam regAddr_t MISC_CLOCK   = 12'h008;
    localparam regAddr_t MISC_TYPE    = 12'h00C;
    localparam regAddr_t REBOOT_ADDR  = 12'h010;
    localparam regAddr_t DEMOD_MODE   = 12'h014;

    // Identification words
    localparam logic [15:0] VER_NUMBER = 16'd431;
    localparam logic [15:0] IMAGE_TYPE = 16'h0102;

endpackage

//--- hdl/legacyDemodTop.sv
// Demodulator output and control top level, joining host registers, symbol routing and DACs
module legacyDemodTop (
    input  logic                                          clk,
    input  logic                                          clockCounterEn,
    // APB host port
    input  logic                                          psel,
    input  logic                                          penable,
    input  logic                                          pwrite,
    input  demodRegMapPkg::regAddr_t                      paddr,
    input  demodRegMapPkg::regData_t                      pwdata,
    output demodRegMapPkg::regData_t                      prdata,
    output logic                                          pready,
    output logic                                          pslverr,
    output demodModePkg::demodMode_t                      demodMode,
    output logic [demodRegMapPkg::BOOT_ADDR_WIDTH-1:0]    rebootAddr,
    output logic                                          rebootPulse,
    // Legacy demodulator symbols
    input  logic                                          trellisSymSync,
    input  logic                                          iSym2xEn,
    input  logic                                          iSymEn,
    input  logic                                          iBit,
    input  logic                                          qBit,
    input  logic                                          auBit,
    input  logic                                          carrierLock,
    input  demodModePkg::sample_t                         iSymData,
    input  demodModePkg::sample_t                         qSymData,
    // Multi-h loop symbols
    input  logic                                          multihLoopEn,
    input  logic                                          multihLoop2xEn,
    input  logic                                          multihDemodLock,
    input  demodModePkg::sample_t                         iMultihLoop,
    input  demodModePkg::sample_t                         qMultihLoop,
    output logic                                          trellisSymEn,
    output logic                                          trellisSym2xEn,
    output demodModePkg::sample_t                         iTrellis,
    output demodModePkg::sample_t                         qTrellis,
    output logic                                          iData,
    output logic                                          qData,
    output logic                                          dataSymEn,
    output logic                                          dataSym2xEn,
    output logic                                          legacyBit,
    output logic                                          demodNLock,
    // DAC sources and pins
    input  logic                                          demod0Sync,
    input  logic                                          demod1Sync,
    input  logic                                          demod2Sync,
    input  demodModePkg::sample_t                         demod0Out,
    input  demodModePkg::sample_t                         demod1Out,
    input  demodModePkg::sample_t                         demod2Out,
    input  logic                                          multihDac0En,
    input  logic                                          multihDac1En,
    input  logic                                          multihDac2En,
    input  logic                                          multihDac0Sync,
    input  logic                                          multihDac1Sync,
    input  logic                                          multihDac2Sync,
    input  demodModePkg::sample_t                         multihDac0Data,
    input  demodModePkg::sample_t                         multihDac1Data,
    input  demodModePkg::sample_t                         multihDac2Data,
    output logic                                          dac0Sync,
    output logic                                          dac1Sync,
    output logic                                          dac2Sync,
    output demodModePkg::dac_t                            dac0Data,
    output demodModePkg::dac_t                            dac1Data,
    output demodModePkg::dac_t                            dac2Data
);

    //******************************
    // Host registers
    //******************************
    demodApbRegs demodApbRegs_inst (.*);

    //******************************
    // Symbol outputs
    //******************************
    symbolRouter symbolRouter_inst (.*);

    //******************************
    // DAC outputs
    //******************************
    // Mode register feeds both datapath blocks directly
    dacOutputMux dacOutputMux_inst (.*);

endmodule

//--- hdl/symbolRouter.sv
// Routes trellis symbols and serial data bits from the legacy demodulator or the multi-h loop
module symbolRouter (
    input  logic                      clk,
    input  logic                      clockCounterEn,
    input  demodModePkg::demodMode_t  demodMode,
    input  logic                      trellisSymSync,
    input  logic                      iSym2xEn,
    input  logic                      iSymEn,
    input  logic                      iBit,
    input  logic                      qBit,
    input  logic                      auBit,
    input  logic                      carrierLock,
    input  demodModePkg::sample_t     iSymData,
    input  demodModePkg::sample_t     qSymData,
    input  logic                      multihLoopEn,
    input  logic                      multihLoop2xEn,
    input  logic                      multihDemodLock,
    input  demodModePkg::sample_t     iMultihLoop,
    input  demodModePkg::sample_t     qMultihLoop,
    output logic                      trellisSymEn,
    output logic                      trellisSym2xEn,
    output demodModePkg::sample_t     iTrellis,
    output demodModePkg::sample_t     qTrellis,
    output logic                      iData,
    output logic                      qData,
    output logic                      dataSymEn,
    output logic                      dataSym2xEn,
    output logic                      legacyBit,
    output logic                      demodNLock
);

    import demodModePkg::*;

    logic multihMode;
    logic fmModes;
    logic aModes;

    assign multihMode = (demodMode == MODE_MULTIH);
    assign fmModes    = (demodMode == MODE_FM) || (demodMode == MODE_2FSK);
    assign aModes     = (demodMode == MODE_AQPSK) || (demodMode == MODE_AUQPSK);

    // Lock follows whichever source owns the trellis outputs
    assign demodNLock = multihMode ? ~multihDemodLock : ~carrierLock;

    //******************************
    // Enables
    //******************************
    always_ff @(posedge clk or posedge clockCounterEn) begin
        if (clockCounterEn) begin
            trellisSymEn   <= 1'b0;
            trellisSym2xEn <= 1'b0;
            dataSymEn      <= 1'b0;
            dataSym2xEn    <= 1'b0;
        end else begin
            trellisSymEn   <= multihMode ? multihLoopEn : trellisSymSync;
            trellisSym2xEn <= multihMode ? multihLoop2xEn : iSym2xEn;
            dataSymEn      <= iSymEn;
            dataSym2xEn    <= iSym2xEn;
        end
    end

    //******************************
    // Samples and bits
    //******************************
    always_ff @(posedge clk) begin
        iTrellis  <= multihMode ? iMultihLoop : iSymData;
        qTrellis  <= multihMode ? qMultihLoop : qSymData;
        // FM discriminator output has the opposite bit sense
        iData     <= fmModes ? ~iBit : iBit;
        qData     <= aModes ? auBit : qBit;
        legacyBit <= iBit;
    end

endmodule

//--- sim/legacyDemodChecks.svh
// Reference model functions and typed compare tasks, included inside the demodulator testbench
`ifndef LEGACY_DEMOD_CHECKS_SVH
`define LEGACY_DEMOD_CHECKS_SVH

//******************************
// Reference model
//******************************
// Trellis samples and lock come from the multi-h loop only in multi-h mode
function automatic sample_t routeSample(input demodMode_t mode, input sample_t legacyVal,
                                        input sample_t multihVal);
    return (mode == MODE_MULTIH) ? multihVal : legacyVal;
endfunction

function automatic logic routeBit(input demodMode_t mode, input logic legacyVal,
                                  input logic multihVal);
    return (mode == MODE_MULTIH) ? multihVal : legacyVal;
endfunction

// FM and 2FSK invert the serial bit
function automatic logic iDataRef(input demodMode_t mode, input logic bitIn);
    return ((mode == MODE_FM) || (mode == MODE_2FSK)) ? ~bitIn : bitIn;
endfunction

function automatic logic qDataRef(input demodMode_t mode, input logic qIn, input logic auIn);
    return ((mode == MODE_AQPSK) || (mode == MODE_AUQPSK)) ? auIn : qIn;
endfunction

function automatic logic dacUsesMultih(input demodMode_t mode, input logic chanEn);
    return chanEn && (mode == MODE_MULTIH);
endfunction

// DAC keeps the upper bits of the sample
function automatic dac_t dacCodeOf(input sample_t sample);
    return sample[SAMPLE_WIDTH-1 -: DAC_WIDTH];
endfunction

//******************************
// Compare tasks
//******************************
task automatic reportMismatch(input string name, input string expHex, input string gotHex);
    errorCount++;
    $display("error %s expected %s got %s", name, expHex, gotHex);
endtask

task automatic checkSample(input string name, input sample_t expected, input sample_t actual);
    if (actual !== expected) begin
        reportMismatch(name, $sformatf("%h", expected), $sformatf("%h", actual));
    end
endtask

task automatic checkDac(input string name, input dac_t expected, input dac_t actual);
    if (actual !== expected) begin
        reportMismatch(name, $sformatf("%h", expected), $sformatf("%h", actual));
    end
endtask

task automatic checkBit(input string name, input logic expected, input logic actual);
    if (actual !== expected) begin
        reportMismatch(name, $sformatf("%h", expected), $sformatf("%h", actual));
    end
endtask

task automatic checkReg(input string name, input regData_t expected, input regData_t actual);
    if (actual !== expected) begin
        reportMismatch(name, $sformatf("%h", expected), $sformatf("%h", actual));
    end
endtask

`endif

//--- sim/legacyDemodTb.sv
// Self-checking testbench for the demodulator top level, run from the vlog.f file list
module legacyDemodTb;

    timeunit 1ns;
    timeprecision 1ps;

    import demodModePkg::*;
    import demodRegMapPkg::*;

    localparam int SYM_CYCLES    = 64;
    localparam int CLOCK_GAP     = 7;
    localparam int APB_CYCLES    = 3;
    localparam int TEST_CYCLES   = 5 + 16 * APB_CYCLES + CLOCK_GAP + 4 + 7 * SYM_CYCLES + 6;
    localparam int TIMEOUT_LIMIT = TEST_CYCLES + 200;

    logic clk = 1'b0;
    logic clockCounterEn;
    logic psel, penable, pwrite, pready, pslverr, rebootPulse;
    regAddr_t paddr;
    regData_t pwdata, prdata;
    demodMode_t demodMode;
    logic [BOOT_ADDR_WIDTH-1:0] rebootAddr;
    logic trellisSymSync, iSym2xEn, iSymEn, iBit, qBit, auBit, carrierLock;
    logic multihLoopEn, multihLoop2xEn, multihDemodLock;
    sample_t iSymData, qSymData, iMultihLoop, qMultihLoop, iTrellis, qTrellis;
    logic trellisSymEn, trellisSym2xEn, iData, qData;
    logic dataSymEn, dataSym2xEn, legacyBit, demodNLock;
    logic demod0Sync, demod1Sync, demod2Sync, dac0Sync, dac1Sync, dac2Sync;
    logic multihDac0En, multihDac1En, multihDac2En;
    logic multihDac0Sync, multihDac1Sync, multihDac2Sync;
    sample_t demod0Out, demod1Out, demod2Out, multihDac0Data, multihDac1Data, multihDac2Data;
    dac_t dac0Data, dac1Data, dac2Data;

    int errorCount, testsRun, testsFailed, cycles, setupCycle, endCycle;
    logic checkOn, symValid;
    demodMode_t tbMode;

    // One-cycle expectations, plus the DAC hold state
    logic expSymEn, expSym2xEn, expIBit, expQBit, expDataEn, expData2xEn, expLegacy;
    sample_t expITrellis, expQTrellis;
    logic expDacSync [NUM_DACS];
    sample_t expDacSample [NUM_DACS];
    dac_t expDacHold [NUM_DACS];

    `include "legacyDemodChecks.svh"

    legacyDemodTop legacyDemodTop_inst (.*);

    always #20 clk = ~clk;

    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycles >= TIMEOUT_LIMIT) begin
            $display("timeout after %0d cycles, the tests did not finish", cycles);
            $display("TESTS FAILED");
            $finish;
        end
    end

    //******************************
    // Stimulus tasks
    //******************************
    task automatic apbTransfer(input logic write, input regAddr_t addr, input regData_t wdata,
                               output regData_t rdata, output logic err);
        @(posedge clk);
        setupCycle = cycles;
        psel    <= 1'b1;
        penable <= 1'b0;
        pwrite  <= write;
        paddr   <= addr;
        pwdata  <= wdata;
        @(posedge clk);
        penable <= 1'b1;
        @(negedge clk);
        checkBit("pready", 1'b1, pready);
        rdata = prdata;
        err   = pslverr;
        @(posedge clk);
        endCycle = cycles;
        psel    <= 1'b0;
        penable <= 1'b0;
        pwrite  <= 1'b0;
    endtask

    task automatic randomizeInputs();
        trellisSymSync  <= $urandom_range(1);
        iSym2xEn        <= $urandom_range(1);
        iSymEn          <= $urandom_range(1);
        iBit            <= $urandom_range(1);
        qBit            <= $urandom_range(1);
        auBit           <= $urandom_range(1);
        carrierLock     <= $urandom_range(1);
        multihLoopEn    <= $urandom_range(1);
        multihLoop2xEn  <= $urandom_range(1);
        multihDemodLock <= $urandom_range(1);
        iSymData        <= sample_t'($urandom);
        qSymData        <= sample_t'($urandom);
        iMultihLoop     <= sample_t'($urandom);
        qMultihLoop     <= sample_t'($urandom);
        demod0Sync      <= $urandom_range(1);
        demod1Sync      <= $urandom_range(1);
        demod2Sync      <= $urandom_range(1);
        demod0Out       <= sample_t'($urandom);
        demod1Out       <= sample_t'($urandom);
        demod2Out       <= sample_t'($urandom);
        multihDac0En    <= $urandom_range(1);
        multihDac1En    <= $urandom_range(1);
        multihDac2En    <= $urandom_range(1);
        multihDac0Sync  <= $urandom_range(1);
        multihDac1Sync  <= $urandom_range(1);
        multihDac2Sync  <= $urandom_range(1);
        multihDac0Data  <= sample_t'($urandom);
        multihDac1Data  <= sample_t'($urandom);
        multihDac2Data  <= sample_t'($urandom);
    endtask

    // Mode takes effect at the edge that ends the access cycle
    task automatic runMode(input demodMode_t mode);
        regData_t rdata;
        logic err;
        apbTransfer(1'b1, DEMOD_MODE, regData_t'(mode), rdata, err);
        tbMode = mode;
        repeat (SYM_CYCLES) begin
            @(posedge clk);
            randomizeInputs();
        end
    endtask

    task automatic finishTest(input string name, input int errorsBefore);
        testsRun++;
        if (errorCount != errorsBefore) begin
            testsFailed++;
            $display("test %s failed with %0d errors", name, errorCount - errorsBefore);
        end else begin
            $display("test %s ok", name);
        end
    endtask

    //******************************
    // Compare process
    //******************************
    always @(negedge clk) begin : compareOutputs
        logic [NUM_DACS-1:0] legacySync, multihEn, multihSync, pinSync;
        sample_t legacyOut [NUM_DACS];
        sample_t multihOut [NUM_DACS];
        dac_t pinData [NUM_DACS];
        logic useMultih;
        legacySync = {demod2Sync, demod1Sync, demod0Sync};
        multihEn   = {multihDac2En, multihDac1En, multihDac0En};
        multihSync = {multihDac2Sync, multihDac1Sync, multihDac0Sync};
        pinSync    = {dac2Sync, dac1Sync, dac0Sync};
        legacyOut  = '{demod0Out, demod1Out, demod2Out};
        multihOut  = '{multihDac0Data, multihDac1Data, multihDac2Data};
        pinData    = '{dac0Data, dac1Data, dac2Data};
        if (checkOn) begin
            checkReg("demodMode", regData_t'(tbMode), regData_t'(demodMode));
            checkBit("demodNLock", ~routeBit(tbMode, carrierLock, multihDemodLock), demodNLock);
            if (!(psel && penable && !pwrite)) begin
                checkReg("prdata", '0, prdata);
            end
            if (symValid) begin
                checkBit("trellisSymEn", expSymEn, trellisSymEn);
                checkBit("trellisSym2xEn", expSym2xEn, trellisSym2xEn);
                checkSample("iTrellis", expITrellis, iTrellis);
                checkSample("qTrellis", expQTrellis, qTrellis);
                checkBit("iData", expIBit, iData);
                checkBit("qData", expQBit, qData);
                checkBit("dataSymEn", expDataEn, dataSymEn);
                checkBit("dataSym2xEn", expData2xEn, dataSym2xEn);
                checkBit("legacyBit", expLegacy, legacyBit);
            end
            expSymEn    = routeBit(tbMode, trellisSymSync, multihLoopEn);
            expSym2xEn  = routeBit(tbMode, iSym2xEn, multihLoop2xEn);
            expITrellis = routeSample(tbMode, iSymData, iMultihLoop);
            expQTrellis = routeSample(tbMode, qSymData, qMultihLoop);
            expIBit     = iDataRef(tbMode, iBit);
            expQBit     = qDataRef(tbMode, qBit, auBit);
            expDataEn   = iSymEn;
            expData2xEn = iSym2xEn;
            expLegacy   = iBit;
            symValid    = 1'b1;
            // Select register then hold register on each channel
            for (int k = 0; k < NUM_DACS; k++) begin
                checkBit($sformatf("dac%0dSync", k), expDacSync[k], pinSync[k]);
                checkDac($sformatf("dac%0dData", k), expDacHold[k], pinData[k]);
                if (expDacSync[k]) begin
                    expDacHold[k] = dacCodeOf(expDacSample[k]);
                end
                useMultih       = dacUsesMultih(tbMode, multihEn[k]);
                expDacSync[k]   = useMultih ? multihSync[k] : legacySync[k];
                expDacSample[k] = useMultih ? multihOut[k] : legacyOut[k];
            end
        end
    end

    //******************************
    // Test sequence
    //******************************
    initial begin : mainSequence
        regData_t rdata, first, second, wdata;
        logic err;
        int errorsBefore, setup1, setup2, clearEnd;
        void'($urandom(33));
        clockCounterEn = 1'b1;
        psel     = 1'b0;
        penable  = 1'b0;
        pwrite   = 1'b0;
        paddr    = '0;
        pwdata   = '0;
        cycles   = 0;
        checkOn  = 1'b0;
        symValid = 1'b0;
        tbMode   = MODE_FM;
        for (int k = 0; k < NUM_DACS; k++) begin
            expDacSync[k]   = 1'b0;
            expDacSample[k] = '0;
            expDacHold[k]   = '0;
        end
        randomizeInputs();
        repeat (5) @(posedge clk);
        clockCounterEn <= 1'b0;
        checkOn        <= 1'b1;

        // Identification and decode
        errorsBefore = errorCount;
        apbTransfer(1'b0, MISC_VERSION, '0, rdata, err);
        checkReg("prdata", regData_t'(VER_NUMBER), rdata >> 16);
        checkBit("pslverr", 1'b0, err);
        apbTransfer(1'b0, MISC_TYPE, '0, rdata, err);
        checkReg("prdata", regData_t'(IMAGE_TYPE), rdata & 32'h0000_FFFF);
        apbTransfer(1'b0, MISC_RESET, '0, rdata, err);
        checkReg("prdata", '0, rdata);
        apbTransfer(1'b0, 12'h0FC, '0, rdata, err);
        checkBit("pslverr", 1'b1, err);
        apbTransfer(1'b1, 12'h0FC, regData_t'(MODE_MULTIH), rdata, err);
        checkBit("pslverr", 1'b1, err);
        finishTest("identification", errorsBefore);

        // Counter restart, then two captures a known distance apart
        errorsBefore = errorCount;
        apbTransfer(1'b1, MISC_CLOCK, '0, rdata, err);
        clearEnd = endCycle;
        apbTransfer(1'b0, MISC_CLOCK, '0, first, err);
        setup1 = setupCycle;
        repeat (CLOCK_GAP) @(posedge clk);
        apbTransfer(1'b0, MISC_CLOCK, '0, second, err);
        setup2 = setupCycle;
        checkReg("prdata", regData_t'(setup1 - clearEnd), first);
        checkReg("prdata", regData_t'(setup2 - setup1), second - first);
        finishTest("clock counter", errorsBefore);

        errorsBefore = errorCount;
        wdata = 32'hA5C3_1E5A;
        apbTransfer(1'b1, REBOOT_ADDR, wdata, rdata, err);
        @(negedge clk);
        checkBit("rebootPulse", 1'b1, rebootPulse);
        checkReg("rebootAddr", regData_t'(wdata[BOOT_ADDR_WIDTH-1:0]), regData_t'(rebootAddr));
        repeat (3) begin
            @(negedge clk);
            checkBit("rebootPulse", 1'b0, rebootPulse);
        end
        finishTest("reboot", errorsBefore);

        errorsBefore = errorCount;
        runMode(MODE_FM);
        runMode(MODE_2FSK);
        runMode(MODE_AQPSK);
        runMode(MODE_AUQPSK);
        runMode(MODE_MULTIH);
        repeat (3) @(posedge clk);
        finishTest("symbol routing", errorsBefore);

        errorsBefore = errorCount;
        runMode(MODE_MULTIH);
        runMode(MODE_FM);
        repeat (3) @(posedge clk);
        finishTest("dac path", errorsBefore);

        $display("tests run %0d, tests failed %0d, errors %0d", testsRun, testsFailed, errorCount);
        if (errorCount == 0) begin
            $display("TESTS PASSED");
        end else begin
            $display("TESTS FAILED");
        end
        $finish;
    end

endmodule

//--- vlog.f
+incdir+sim
hdl/demodModePkg.sv
hdl/demodRegMapPkg.sv
hdl/demodApbRegs.sv
hdl/symbolRouter.sv
hdl/dacOutputMux.sv
hdl/legacyDemodTop.sv
sim/legacyDemodTb.sv
